/* hw/conv_pkg.sv */
package conv_pkg;

	// row geometry
	localparam int PIXELS_PER_ROW = 32;
	localparam int TAPS = 3;
	localparam int RESULTS_PER_ROW = PIXELS_PER_ROW - TAPS + 1;

	// buffer entries, also the credit count after reset
	localparam int BUF_DEPTH = 8;

	// signed pixel and accumulator widths
	typedef logic signed [7:0] pixel_t;
	typedef logic signed [17:0] acc_t;

	// pixel i sits in bits 8i+7 .. 8i
	typedef logic [PIXELS_PER_ROW*8-1:0] row_t;

	// needs to hold the value BUF_DEPTH itself
	typedef logic [3:0] credit_t;
	typedef logic [2:0] buf_addr_t;

	// fixed second-difference kernel
	localparam pixel_t KERNEL [TAPS] = '{-8'sd1, 8'sd2, -8'sd1};

	// one pixel on its way from the loader to the engine
	typedef struct packed {
		pixel_t pixel;
		logic last;
	} pixel_beat_t;

	// one convolution output on the result stream
	typedef struct packed {
		acc_t value;
		logic last;
	} result_beat_t;

	typedef enum logic {
		IDLE,
		SEND
	} loader_state_t;

	typedef enum logic {
		FILL,
		RUN
	} engine_state_t;

endpackage

/* hw/row_loader.sv */
module row_loader (
	input logic clk,
	input logic rst,
	input logic start,
	input conv_pkg::row_t row,
	output logic busy,
	output logic push,
	output conv_pkg::pixel_beat_t push_beat,
	input logic credit_return
);

	conv_pkg::loader_state_t state;

	// latched copy of the row being sent
	conv_pkg::row_t row_q;

	// index of the next pixel to push
	logic [4:0] idx;

	// free entries in the pixel buffer
	conv_pkg::credit_t credit_count;

	logic take_start;
	logic last_pixel;

	assign busy = (state == conv_pkg::SEND);
	assign take_start = start && !busy;
	assign last_pixel = (idx == 5'(conv_pkg::PIXELS_PER_ROW - 1));

	// send only while the buffer has room
	assign push = busy && (credit_count != '0);

	assign push_beat.pixel = row_q[{idx, 3'b000} +: 8];
	assign push_beat.last = last_pixel;

	always_ff @(posedge clk) begin
		if (take_start) begin
			row_q <= row;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= conv_pkg::IDLE;
			idx <= '0;
		end else begin
			case (state)
				conv_pkg::IDLE: begin
					if (start) begin
						state <= conv_pkg::SEND;
						idx <= '0;
					end
				end
				conv_pkg::SEND: begin
					if (push) begin
						idx <= idx + 5'd1;
						// pixel 31 done, busy drops next cycle
						if (last_pixel) begin
							state <= conv_pkg::IDLE;
						end
					end
				end
				default: begin
					state <= conv_pkg::IDLE;
				end
			endcase
		end
	end

	// a push and a return together cancel out
	always_ff @(posedge clk) begin
		if (rst) begin
			credit_count <= conv_pkg::credit_t'(conv_pkg::BUF_DEPTH);
		end else begin
			case ({push, credit_return})
				2'b10: credit_count <= credit_count - 4'd1;
				2'b01: credit_count <= credit_count + 4'd1;
				default: credit_count <= credit_count;
			endcase
		end
	end

endmodule

/* hw/pixel_buffer.sv */
module pixel_buffer (
	input logic clk,
	input logic rst,
	input logic push,
	input conv_pkg::pixel_beat_t push_beat,
	input logic pop,
	output logic avail,
	output conv_pkg::pixel_beat_t head_beat,
	output logic credit_return
);

	conv_pkg::pixel_beat_t mem [conv_pkg::BUF_DEPTH];

	conv_pkg::buf_addr_t wr_ptr;
	conv_pkg::buf_addr_t rd_ptr;

	// entries currently held
	conv_pkg::credit_t count;

	assign avail = (count != '0);
	assign head_beat = mem[rd_ptr];

	// no full check here, the loader only pushes with a credit in hand
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_beat;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			// pointers wrap at the buffer depth
			if (push) begin
				wr_ptr <= wr_ptr + 3'd1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 3'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10: count <= count + 4'd1;
				2'b01: count <= count - 4'd1;
				default: count <= count;
			endcase
		end
	end

	// one credit back per entry freed, a cycle after the pop
	always_ff @(posedge clk) begin
		if (rst) begin
			credit_return <= 1'b0;
		end else begin
			credit_return <= pop;
		end
	end

endmodule

/* hw/mac_stage.sv */
module mac_stage (
	input logic clk,
	input logic rst,
	input logic en,
	input conv_pkg::pixel_t pixel,
	input conv_pkg::pixel_t weight,
	input conv_pkg::acc_t sum_in,
	output conv_pkg::acc_t sum_out
);

	conv_pkg::acc_t product;

	// both operands sign extended to the accumulator width
	assign product = conv_pkg::acc_t'(weight) * conv_pkg::acc_t'(pixel);

	always_ff @(posedge clk) begin
		if (rst) begin
			sum_out <= '0;
		end else if (en) begin
			sum_out <= sum_in + product;
		end
	end

endmodule

/* hw/conv_engine.sv */
module conv_engine (
	input logic clk,
	input logic rst,
	input logic avail,
	input conv_pkg::pixel_beat_t head_beat,
	output logic pop,
	output logic result_valid,
	output conv_pkg::result_beat_t result_beat,
	input logic result_ready,
	output logic row_done
);

	conv_pkg::engine_state_t state;

	// pixels popped so far in this row
	logic [4:0] pix_cnt;

	// partial sums along the transposed chain
	conv_pkg::acc_t sum0;
	conv_pkg::acc_t sum1;
	conv_pkg::acc_t sum2;

	logic out_free;
	logic emit;
	logic res_last;
	logic accept;

	// result slot is free when empty or being taken this cycle
	assign out_free = !result_valid || result_ready;
	assign pop = avail && out_free;

	// warm-up pops only fill the chain
	assign emit = pop && (state == conv_pkg::RUN);
	assign accept = result_valid && result_ready;

	mac_stage i_stage0 (
		.clk(clk),
		.rst(rst),
		.en(pop),
		.pixel(head_beat.pixel),
		.weight(conv_pkg::KERNEL[2]),
		.sum_in('0),
		.sum_out(sum0)
	);

	mac_stage i_stage1 (
		.clk(clk),
		.rst(rst),
		.en(pop),
		.pixel(head_beat.pixel),
		.weight(conv_pkg::KERNEL[1]),
		.sum_in(sum0),
		.sum_out(sum1)
	);

	// the last stage doubles as the result register
	mac_stage i_stage2 (
		.clk(clk),
		.rst(rst),
		.en(pop),
		.pixel(head_beat.pixel),
		.weight(conv_pkg::KERNEL[0]),
		.sum_in(sum1),
		.sum_out(sum2)
	);

	assign result_beat.value = sum2;
	assign result_beat.last = res_last;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= conv_pkg::FILL;
			pix_cnt <= '0;
		end else if (pop) begin
			if (head_beat.last) begin
				// sums spanning two rows never get out
				state <= conv_pkg::FILL;
				pix_cnt <= '0;
			end else begin
				pix_cnt <= pix_cnt + 5'd1;
				if (state == conv_pkg::FILL && pix_cnt == 5'(conv_pkg::TAPS - 2)) begin
					state <= conv_pkg::RUN;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (emit) begin
			res_last <= head_beat.last;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid <= 1'b0;
			row_done <= 1'b0;
		end else begin
			if (emit) begin
				result_valid <= 1'b1;
			end else if (result_ready) begin
				result_valid <= 1'b0;
			end
			// pulse once the final result has left
			row_done <= accept && result_beat.last;
		end
	end

endmodule

/* hw/conv_top.sv */
module conv_top (
	input logic clk,
	input logic rst,
	input logic start,
	input conv_pkg::row_t row,
	output logic busy,
	output logic result_valid,
	output conv_pkg::result_beat_t result_beat,
	input logic result_ready,
	output logic row_done
);

	// loader to buffer
	logic push;
	conv_pkg::pixel_beat_t push_beat;
	logic credit_return;

	// buffer to engine
	logic avail;
	logic pop;
	conv_pkg::pixel_beat_t head_beat;

	row_loader i_loader (
		.clk(clk),
		.rst(rst),
		.start(start),
		.row(row),
		.busy(busy),
		.push(push),
		.push_beat(push_beat),
		.credit_return(credit_return)
	);

	pixel_buffer i_buffer (
		.clk(clk),
		.rst(rst),
		.push(push),
		.push_beat(push_beat),
		.pop(pop),
		.avail(avail),
		.head_beat(head_beat),
		.credit_return(credit_return)
	);

	conv_engine i_engine (
		.clk(clk),
		.rst(rst),
		.avail(avail),
		.head_beat(head_beat),
		.pop(pop),
		.result_valid(result_valid),
		.result_beat(result_beat),
		.result_ready(result_ready),
		.row_done(row_done)
	);

endmodule

/* test/conv_checker.sv */
module conv_checker (
	input logic clk,
	input logic rst,
	input logic push,
	input logic credit_return,
	input conv_pkg::credit_t credit_count,
	input logic pop,
	input logic avail,
	input logic result_valid,
	input conv_pkg::result_beat_t result_beat,
	input logic result_ready
);

	// credits and buffer fill rebuilt from the handshakes alone
	conv_pkg::credit_t credit_model;
	conv_pkg::credit_t fill_model;

	always_ff @(posedge clk) begin
		if (rst) begin
			credit_model <= conv_pkg::credit_t'(conv_pkg::BUF_DEPTH);
			fill_model <= '0;
		end else begin
			credit_model <= credit_model - conv_pkg::credit_t'(push)
				+ conv_pkg::credit_t'(credit_return);
			fill_model <= fill_model + conv_pkg::credit_t'(push)
				- conv_pkg::credit_t'(pop);
		end
	end

	// every push spends a credit the loader holds
	push_needs_credit: assert property (
		@(posedge clk) disable iff (rst) push |-> (credit_model != '0)
	) else $error("push issued with no credit left");

	credit_in_range: assert property (
		@(posedge clk) disable iff (rst) credit_count <= conv_pkg::BUF_DEPTH
	) else $error("credit count above buffer depth");

	// output stream holds while stalled
	result_held: assert property (
		@(posedge clk) disable iff (rst)
		(result_valid && !result_ready) |=> (result_valid && $stable(result_beat))
	) else $error("result changed while ready was low");

	pop_needs_data: assert property (
		@(posedge clk) disable iff (rst) pop |-> (avail && fill_model != '0)
	) else $error("pop from an empty buffer");

endmodule

bind conv_top conv_checker i_checker (
	.clk(clk),
	.rst(rst),
	.push(push),
	.credit_return(credit_return),
	.credit_count(i_loader.credit_count),
	.pop(pop),
	.avail(avail),
	.result_valid(result_valid),
	.result_beat(result_beat),
	.result_ready(result_ready)
);

/* test/conv_tb.sv */
module conv_tb;

	logic clk;
	logic rst;
	logic start;
	conv_pkg::row_t row;
	logic busy;
	logic result_valid;
	conv_pkg::result_beat_t result_beat;
	logic result_ready;
	logic row_done;

	// second-difference kernel, taps 0 to 2
	int kernel_taps [conv_pkg::TAPS] = '{-1, 2, -1};

	int fixed_rows = 3;
	int random_rows = 20;

	logic [31:0] lfsr_state = 32'hac52;
	logic random_ready = 1'b0;
	logic next_ready = 1'b1;

	conv_pkg::result_beat_t expected [$];
	conv_pkg::result_beat_t want;
	int starts_taken = 0;
	int rows_done = 0;
	logic last_pending = 1'b0;

	conv_top i_dut (
		.clk(clk),
		.rst(rst),
		.start(start),
		.row(row),
		.busy(busy),
		.result_valid(result_valid),
		.result_beat(result_beat),
		.result_ready(result_ready),
		.row_done(row_done)
	);

	always #4 clk = ~clk;

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic random_bit();
		lfsr_state = lfsr_step(lfsr_state);
		return lfsr_state[0];
	endfunction

	function automatic conv_pkg::row_t random_row();
		conv_pkg::row_t r;
		for (int b = 0; b < conv_pkg::PIXELS_PER_ROW * 8; b++) begin
			r[b] = random_bit();
		end
		return r;
	endfunction

	// queues the 30 results of a row, result k = sum of tap j times pixel k+j
	function automatic void expect_row(input conv_pkg::row_t r);
		conv_pkg::result_beat_t beat;
		int acc;
		int px;
		for (int k = 0; k < conv_pkg::RESULTS_PER_ROW; k++) begin
			acc = 0;
			for (int j = 0; j < conv_pkg::TAPS; j++) begin
				px = int'($signed(r[8*(k+j) +: 8]));
				acc += kernel_taps[j] * px;
			end
			beat.value = conv_pkg::acc_t'(acc);
			beat.last = (k == conv_pkg::RESULTS_PER_ROW - 1);
			expected.push_back(beat);
		end
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h",
				name, got, exp));
		end
	endtask

	task automatic send_row(input conv_pkg::row_t r);
		@(posedge clk);
		while (busy) begin
			@(posedge clk);
		end
		#1;
		start = 1'b1;
		row = r;
		expect_row(r);
		starts_taken++;
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	task automatic wait_drained();
		while (expected.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
	endtask

	// ready stays high unless back-pressure is switched on
	// drawn mid-cycle so it never shares a time step with row draws
	always @(negedge clk) begin
		if (random_ready) begin
			next_ready = random_bit();
		end else begin
			next_ready = 1'b1;
		end
	end

	always @(posedge clk) begin
		#1;
		result_ready = next_ready;
	end

	always @(posedge clk) begin
		if (!rst) begin
			if (row_done) begin
				if (!last_pending) begin
					stop_with_failure("row_done pulsed without a preceding last result");
				end
				last_pending = 1'b0;
				rows_done++;
			end
			if (result_valid && result_ready) begin
				if (expected.size() == 0) begin
					stop_with_failure("result accepted with no expected value queued");
				end
				want = expected.pop_front();
				check_value("result_beat.value", 32'(result_beat.value), 32'(want.value));
				check_value("result_beat.last", 32'(result_beat.last), 32'(want.last));
				last_pending = result_beat.last;
			end
		end
	end

	initial begin
		int limit;
		// four cycles per pixel of every row, plus slack for reset and drain
		limit = (fixed_rows + random_rows) * conv_pkg::PIXELS_PER_ROW * 4 + 200;
		repeat (limit) @(posedge clk);
		stop_with_failure("timeout, results did not finish in time");
	end

	initial begin
		conv_pkg::row_t r;
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		row = '0;
		result_ready = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		// quiet after reset
		repeat (4) begin
			@(posedge clk);
			check_value("busy", 32'(busy), 32'd0);
			check_value("result_valid", 32'(result_valid), 32'd0);
			check_value("row_done", 32'(row_done), 32'd0);
		end

		for (int i = 0; i < conv_pkg::PIXELS_PER_ROW; i++) begin
			r[8*i +: 8] = 8'sd1;
		end
		send_row(r);
		for (int i = 0; i < conv_pkg::PIXELS_PER_ROW; i++) begin
			r[8*i +: 8] = 8'(i - 16);
		end
		send_row(r);
		// full-scale swing, largest magnitude the kernel can reach
		for (int i = 0; i < conv_pkg::PIXELS_PER_ROW; i++) begin
			r[8*i +: 8] = (i % 2 == 0) ? 8'h80 : 8'h7f;
		end
		send_row(r);
		wait_drained();

		random_ready = 1'b1;
		for (int n = 0; n < random_rows; n++) begin
			send_row(random_row());
			if (n == random_rows / 2) begin
				// loader is mid-row, this start must be dropped
				check_value("busy", 32'(busy), 32'd1);
				start = 1'b1;
				row = random_row();
				@(posedge clk);
				#1;
				start = 1'b0;
			end
		end
		wait_drained();

		if (rows_done != starts_taken) begin
			stop_with_failure($sformatf("%0d rows completed but %0d starts were taken",
				rows_done, starts_taken));
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

/* build.f */
hw/conv_pkg.sv
hw/row_loader.sv
hw/pixel_buffer.sv
hw/mac_stage.sv
hw/conv_engine.sv
hw/conv_top.sv
test/conv_checker.sv
test/conv_tb.sv
